// File: hw/icache_bus_pkg.sv
package icache_bus_pkg;

  // read response codes, same encoding as the refill bus
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // response towards the fetch unit
  typedef struct packed {
    logic [icache_geom_pkg::WORD_W-1:0] data;
    resp_e                              resp;
  } fetch_rsp_t;

  // single-beat response from memory
  typedef struct packed {
    logic [icache_geom_pkg::WORD_W-1:0] data;
    resp_e                              resp;
  } mem_rsp_t;

  // configuration register select
  typedef enum logic [1:0] {
    CTRL       = 2'd0,
    HIT_COUNT  = 2'd1,
    MISS_COUNT = 2'd2
  } cfg_addr_e;

endpackage

// File: hw/icache_ctrl.sv
module icache_ctrl (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                ar_valid_i,
  output logic                                ar_ready_o,
  input  icache_geom_pkg::fetch_addr_u        ar_addr_i,
  output logic                                r_valid_o,
  input  logic                                r_ready_i,
  output icache_bus_pkg::fetch_rsp_t          r_rsp_o,
  output logic                                mem_ar_valid_o,
  input  logic                                mem_ar_ready_i,
  output logic [icache_geom_pkg::ADDR_W-1:0]  mem_ar_addr_o,
  input  logic                                mem_r_valid_i,
  output logic                                mem_r_ready_o,
  input  icache_bus_pkg::mem_rsp_t            mem_r_rsp_i,
  input  logic                                enable_i,
  input  logic                                flush_req_i,
  output logic                                flush_ack_o,
  output logic                                hit_o,
  output logic                                miss_o,
  output logic [icache_geom_pkg::TAG_W-1:0]   lookup_tag_o,
  output logic [icache_geom_pkg::INDEX_W-1:0] lookup_index_o,
  input  logic                                tag_hit_i,
  input  logic [icache_geom_pkg::WAY_W-1:0]   tag_hit_way_i,
  input  logic [icache_geom_pkg::WAY_W-1:0]   victim_way_i,
  output logic                                fill_we_o,
  output logic [icache_geom_pkg::WAY_W-1:0]   fill_way_o,
  output logic [icache_geom_pkg::INDEX_W-1:0] fill_index_o,
  output logic [icache_geom_pkg::TAG_W-1:0]   fill_tag_o,
  output logic                                fill_valid_o,
  output logic                                clear_o,
  output logic [icache_geom_pkg::NUM_WAYS-1:0] ram_en_o,
  output logic [icache_geom_pkg::NUM_WAYS-1:0] ram_we_o,
  output logic [icache_geom_pkg::INDEX_W-1:0] ram_addr_o,
  output logic [icache_geom_pkg::WORD_W-1:0]  ram_wdata_o,
  input  logic [icache_geom_pkg::NUM_WAYS-1:0][icache_geom_pkg::WORD_W-1:0] ram_rdata_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FLUSH,
    ST_HIT_RD,
    ST_REFILL_AR,
    ST_REFILL_R,
    ST_RESP
  } state_e;

  state_e                            state_q;
  state_e                            state_d;
  icache_geom_pkg::fetch_addr_u      line_addr;
  icache_geom_pkg::fetch_addr_u      addr_q;  // line address of the fetch in flight
  logic [icache_geom_pkg::WAY_W-1:0] way_q;
  logic                              fill_en_q;  // enable seen when the fetch was taken
  icache_bus_pkg::fetch_rsp_t        rsp_q;
  logic                              accept;
  logic                              refill_done;
  logic                              refill_ok;

  // a pending flush blocks new fetches
  assign ar_ready_o     = (state_q == ST_IDLE) && !flush_req_i;
  assign accept         = ar_valid_i && ar_ready_o;
  assign mem_ar_valid_o = (state_q == ST_REFILL_AR);
  assign mem_r_ready_o  = (state_q == ST_REFILL_R);
  assign r_valid_o      = (state_q == ST_RESP);
  assign r_rsp_o        = rsp_q;
  assign mem_ar_addr_o  = addr_q.raw;

  assign refill_done = mem_r_valid_i && mem_r_ready_o;
  assign refill_ok   = refill_done && fill_en_q && (mem_r_rsp_i.resp == icache_bus_pkg::OKAY);

  assign flush_ack_o = (state_q == ST_FLUSH);
  assign clear_o     = (state_q == ST_FLUSH);

  assign hit_o  = accept && enable_i && tag_hit_i;
  assign miss_o = accept && enable_i && !tag_hit_i;

  assign lookup_tag_o   = ar_addr_i.fields.tag;
  assign lookup_index_o = ar_addr_i.fields.index;

  always_comb begin
    line_addr               = ar_addr_i;
    line_addr.fields.offset = '0;
  end

  // tag store updates
  always_comb begin
    fill_we_o    = 1'b0;
    fill_way_o   = way_q;
    fill_index_o = addr_q.fields.index;
    fill_tag_o   = addr_q.fields.tag;
    fill_valid_o = 1'b0;
    if (accept && !enable_i && tag_hit_i) begin
      fill_we_o    = 1'b1;  // drop a copy that bypassed fetches leave behind
      fill_way_o   = tag_hit_way_i;
      fill_index_o = ar_addr_i.fields.index;
      fill_tag_o   = ar_addr_i.fields.tag;
    end else if (miss_o) begin
      fill_we_o    = 1'b1;  // victim invalid until the refill lands
      fill_way_o   = victim_way_i;
      fill_index_o = ar_addr_i.fields.index;
      fill_tag_o   = ar_addr_i.fields.tag;
    end else if (refill_ok) begin
      fill_we_o    = 1'b1;
      fill_valid_o = 1'b1;
    end
  end

  // data RAM access, read on accept, write on a good refill
  always_comb begin
    ram_en_o    = '0;
    ram_we_o    = '0;
    ram_addr_o  = addr_q.fields.index;
    ram_wdata_o = mem_r_rsp_i.data;
    if (hit_o) begin
      ram_en_o[tag_hit_way_i] = 1'b1;
      ram_addr_o              = ar_addr_i.fields.index;
    end else if (refill_ok) begin
      ram_en_o[way_q] = 1'b1;
      ram_we_o[way_q] = 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (flush_req_i) begin
          state_d = ST_FLUSH;
        end else if (accept) begin
          state_d = hit_o ? ST_HIT_RD : ST_REFILL_AR;
        end
      end
      ST_FLUSH:     state_d = ST_IDLE;
      ST_HIT_RD:    state_d = ST_RESP;  // RAM data arrives here
      ST_REFILL_AR: if (mem_ar_ready_i) state_d = ST_REFILL_R;
      ST_REFILL_R:  if (mem_r_valid_i) state_d = ST_RESP;
      ST_RESP:      if (r_ready_i) state_d = ST_IDLE;
      default:      state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ST_IDLE;
      fill_en_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        fill_en_q <= enable_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= line_addr;
      way_q  <= tag_hit_i ? tag_hit_way_i : victim_way_i;
    end
    if (state_q == ST_HIT_RD) begin
      rsp_q.data <= ram_rdata_i[way_q];
      rsp_q.resp <= icache_bus_pkg::OKAY;
    end else if (refill_done) begin
      rsp_q.data <= mem_r_rsp_i.data;  // errors pass straight through
      rsp_q.resp <= mem_r_rsp_i.resp;
    end
  end

endmodule

// File: hw/icache_ctrl_regs.sv
module icache_ctrl_regs (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cfg_we_i,
  input  icache_bus_pkg::cfg_addr_e cfg_addr_i,
  input  logic [31:0]               cfg_wdata_i,
  output logic [31:0]               cfg_rdata_o,
  output logic                      enable_o,
  output logic                      flush_req_o,
  input  logic                      flush_ack_i,
  input  logic                      hit_i,
  input  logic                      miss_i
);

  logic        enable_q;
  logic        flush_pend_q;
  logic [31:0] hit_cnt_q;
  logic [31:0] miss_cnt_q;
  logic        ctrl_wr;

  assign ctrl_wr = cfg_we_i && (cfg_addr_i == icache_bus_pkg::CTRL);

  always_ff @(posedge clk) begin
    if (rst) begin
      enable_q     <= 1'b1;  // cache on out of reset
      flush_pend_q <= 1'b0;
    end else begin
      if (flush_ack_i) begin
        flush_pend_q <= 1'b0;
      end
      if (ctrl_wr) begin
        enable_q <= cfg_wdata_i[0];
        if (cfg_wdata_i[1]) begin
          flush_pend_q <= 1'b1;  // a new request wins over the ack
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hit_cnt_q  <= '0;
      miss_cnt_q <= '0;
    end else begin
      if (hit_i) begin
        hit_cnt_q <= hit_cnt_q + 1'b1;
      end
      if (miss_i) begin
        miss_cnt_q <= miss_cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_addr_i)
      icache_bus_pkg::CTRL:       cfg_rdata_o = {30'b0, flush_pend_q, enable_q};
      icache_bus_pkg::HIT_COUNT:  cfg_rdata_o = hit_cnt_q;
      icache_bus_pkg::MISS_COUNT: cfg_rdata_o = miss_cnt_q;
      default:                    cfg_rdata_o = '0;
    endcase
  end

  assign enable_o    = enable_q;
  assign flush_req_o = flush_pend_q;

endmodule

// File: hw/icache_data_ram.sv
module icache_data_ram #(
  parameter int DEPTH = 64,
  parameter int WIDTH = 64
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  // one access per cycle, lines are always written whole
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];  // valid the cycle after en_i
      end
    end
  end

endmodule

// File: hw/icache_geom_pkg.sv
package icache_geom_pkg;

  localparam int ADDR_W   = 32;
  localparam int TAG_W    = 23;
  localparam int INDEX_W  = 6;
  localparam int OFFSET_W = 3;  // byte within the 64-bit word

  localparam int NUM_SETS = 64;
  localparam int NUM_WAYS = 2;
  localparam int WAY_W    = $clog2(NUM_WAYS);

  localparam int WORD_W   = 64;

  // address split for lookup
  // |31      9|8     3|2      0|
  // |   tag   | index | offset |
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } fetch_fields_t;

  // raw view for bus addresses, fields view for the tag lookup
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    fetch_fields_t     fields;
  } fetch_addr_u;

endpackage

// File: hw/icache_tag_store.sv
module icache_tag_store (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [icache_geom_pkg::TAG_W-1:0]   lookup_tag_i,
  input  logic [icache_geom_pkg::INDEX_W-1:0] lookup_index_i,
  output logic                                hit_o,
  output logic [icache_geom_pkg::WAY_W-1:0]   hit_way_o,
  output logic [icache_geom_pkg::WAY_W-1:0]   victim_way_o,
  input  logic                                fill_we_i,
  input  logic [icache_geom_pkg::WAY_W-1:0]   fill_way_i,
  input  logic [icache_geom_pkg::INDEX_W-1:0] fill_index_i,
  input  logic [icache_geom_pkg::TAG_W-1:0]   fill_tag_i,
  input  logic                                fill_valid_i,
  input  logic                                clear_i
);

  logic [icache_geom_pkg::TAG_W-1:0] tag_mem [icache_geom_pkg::NUM_WAYS]
                                             [icache_geom_pkg::NUM_SETS];
  logic [icache_geom_pkg::NUM_WAYS-1:0][icache_geom_pkg::NUM_SETS-1:0] valid_q;

  logic [icache_geom_pkg::NUM_WAYS-1:0] way_hit;
  logic [icache_geom_pkg::NUM_WAYS-1:0] way_free;
  logic [icache_geom_pkg::WAY_W-1:0]    rr_q;  // free-running victim pointer

  // all ways compared in parallel
  always_comb begin
    for (int w = 0; w < icache_geom_pkg::NUM_WAYS; w++) begin
      way_hit[w]  = valid_q[w][lookup_index_i] &&
                    (tag_mem[w][lookup_index_i] == lookup_tag_i);
      way_free[w] = !valid_q[w][lookup_index_i];
    end
  end

  assign hit_o = |way_hit;

  // lowest matching way wins, invalid ways are filled before the pointer is used
  always_comb begin
    hit_way_o    = '0;
    victim_way_o = rr_q;
    for (int w = icache_geom_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_way_o = icache_geom_pkg::WAY_W'(w);
      end
      if (way_free[w]) begin
        victim_way_o = icache_geom_pkg::WAY_W'(w);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_we_i) begin
      tag_mem[fill_way_i][fill_index_i] <= fill_tag_i;
    end
  end

  // a fill with fill_valid_i low invalidates the line while the refill runs
  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      valid_q <= '0;
    end else if (fill_we_i) begin
      valid_q[fill_way_i][fill_index_i] <= fill_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_q + 1'b1;  // advances every cycle
    end
  end

endmodule

// File: hw/icache_top.sv
module icache_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  input  icache_geom_pkg::fetch_addr_u       ar_addr_i,
  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  output icache_bus_pkg::fetch_rsp_t         r_rsp_o,
  output logic                               mem_ar_valid_o,
  input  logic                               mem_ar_ready_i,
  output logic [icache_geom_pkg::ADDR_W-1:0] mem_ar_addr_o,
  input  logic                               mem_r_valid_i,
  output logic                               mem_r_ready_o,
  input  icache_bus_pkg::mem_rsp_t           mem_r_rsp_i,
  input  logic                               cfg_we_i,
  input  icache_bus_pkg::cfg_addr_e          cfg_addr_i,
  input  logic [31:0]                        cfg_wdata_i,
  output logic [31:0]                        cfg_rdata_o
);

  logic                                enable;
  logic                                flush_req;
  logic                                flush_ack;
  logic                                hit;
  logic                                miss;
  logic [icache_geom_pkg::TAG_W-1:0]   lookup_tag;
  logic [icache_geom_pkg::INDEX_W-1:0] lookup_index;
  logic                                tag_hit;
  logic [icache_geom_pkg::WAY_W-1:0]   tag_hit_way;
  logic [icache_geom_pkg::WAY_W-1:0]   victim_way;
  logic                                fill_we;
  logic [icache_geom_pkg::WAY_W-1:0]   fill_way;
  logic [icache_geom_pkg::INDEX_W-1:0] fill_index;
  logic [icache_geom_pkg::TAG_W-1:0]   fill_tag;
  logic                                fill_valid;
  logic                                clear;
  logic [icache_geom_pkg::NUM_WAYS-1:0] ram_en;
  logic [icache_geom_pkg::NUM_WAYS-1:0] ram_we;
  logic [icache_geom_pkg::INDEX_W-1:0] ram_addr;
  logic [icache_geom_pkg::WORD_W-1:0]  ram_wdata;
  logic [icache_geom_pkg::NUM_WAYS-1:0][icache_geom_pkg::WORD_W-1:0] ram_rdata;

  icache_ctrl_regs ctrl_regs_inst (
    .clk         (clk),
    .rst         (rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .enable_o    (enable),
    .flush_req_o (flush_req),
    .flush_ack_i (flush_ack),
    .hit_i       (hit),
    .miss_i      (miss)
  );

  icache_ctrl ctrl_inst (
    .clk            (clk),
    .rst            (rst),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .ar_addr_i      (ar_addr_i),
    .r_valid_o      (r_valid_o),
    .r_ready_i      (r_ready_i),
    .r_rsp_o        (r_rsp_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_rsp_i    (mem_r_rsp_i),
    .enable_i       (enable),
    .flush_req_i    (flush_req),
    .flush_ack_o    (flush_ack),
    .hit_o          (hit),
    .miss_o         (miss),
    .lookup_tag_o   (lookup_tag),
    .lookup_index_o (lookup_index),
    .tag_hit_i      (tag_hit),
    .tag_hit_way_i  (tag_hit_way),
    .victim_way_i   (victim_way),
    .fill_we_o      (fill_we),
    .fill_way_o     (fill_way),
    .fill_index_o   (fill_index),
    .fill_tag_o     (fill_tag),
    .fill_valid_o   (fill_valid),
    .clear_o        (clear),
    .ram_en_o       (ram_en),
    .ram_we_o       (ram_we),
    .ram_addr_o     (ram_addr),
    .ram_wdata_o    (ram_wdata),
    .ram_rdata_i    (ram_rdata)
  );

  icache_tag_store tag_store_inst (
    .clk            (clk),
    .rst            (rst),
    .lookup_tag_i   (lookup_tag),
    .lookup_index_i (lookup_index),
    .hit_o          (tag_hit),
    .hit_way_o      (tag_hit_way),
    .victim_way_o   (victim_way),
    .fill_we_i      (fill_we),
    .fill_way_i     (fill_way),
    .fill_index_i   (fill_index),
    .fill_tag_i     (fill_tag),
    .fill_valid_i   (fill_valid),
    .clear_i        (clear)
  );

  // one data RAM per way
  for (genvar w = 0; w < icache_geom_pkg::NUM_WAYS; w++) begin : g_way
    icache_data_ram #(
      .DEPTH (icache_geom_pkg::NUM_SETS),
      .WIDTH (icache_geom_pkg::WORD_W)
    ) data_ram_inst (
      .clk     (clk),
      .en_i    (ram_en[w]),
      .we_i    (ram_we[w]),
      .addr_i  (ram_addr),
      .wdata_i (ram_wdata),
      .rdata_o (ram_rdata[w])
    );
  end

endmodule

// File: icache.f
hw/icache_geom_pkg.sv
hw/icache_bus_pkg.sv
hw/icache_data_ram.sv
hw/icache_tag_store.sv
hw/icache_ctrl_regs.sv
hw/icache_ctrl.sv
hw/icache_top.sv
verif/icache_tb_clk.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module icache_tb -f icache.f -o icache_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/icache_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -qx "test passed" sim.log && exit 0 || exit 1

// File: verif/icache_mem_model.sv
module icache_mem_model (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [1:0]               gate_i,  // random slots, bit 0 address, bit 1 data
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,
  input  logic [31:0]              ar_addr_i,
  output logic                     r_valid_o,
  input  logic                     r_ready_i,
  output icache_bus_pkg::mem_rsp_t r_rsp_o
);

  logic                     ar_ready_q = 1'b0;
  logic                     r_valid_q  = 1'b0;
  icache_bus_pkg::mem_rsp_t rsp_q      = '0;
  logic                     pending_q  = 1'b0;  // address taken, data not yet sent
  logic [31:0]              addr_q     = '0;

  assign ar_ready_o = ar_ready_q;
  assign r_valid_o  = r_valid_q;
  assign r_rsp_o    = rsp_q;

  always @(posedge clk) begin
    if (rst) begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
      pending_q  <= 1'b0;
    end else begin
      if (ar_valid_i && ar_ready_q) begin
        pending_q  <= 1'b1;
        addr_q     <= ar_addr_i;
        ar_ready_q <= 1'b0;  // one read at a time
      end else if (!pending_q) begin
        ar_ready_q <= gate_i[0];
      end
      if (r_valid_q && r_ready_i) begin
        r_valid_q <= 1'b0;
        pending_q <= 1'b0;
      end else if (pending_q && !r_valid_q && gate_i[1]) begin
        r_valid_q  <= 1'b1;
        rsp_q.data <= {~addr_q, addr_q};  // inverted address above the address
        if (addr_q[31:28] == 4'hF) begin
          rsp_q.resp <= icache_bus_pkg::SLVERR;  // error region
        end else begin
          rsp_q.resp <= icache_bus_pkg::OKAY;
        end
      end
    end
  end

endmodule

// File: verif/icache_tb.sv
module icache_tb;

  localparam int          WAIT_LIMIT = 200;  // cycles per wait
  localparam logic [31:0] LFSR_SEED  = 32'd68192;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
  localparam logic [31:0] ADDR_A     = 32'h0000_2048;  // set 9
  localparam logic [31:0] ADDR_B     = 32'h0001_204A;  // set 9 with another tag
  localparam logic [31:0] ADDR_C     = 32'h0000_AB40;  // set 40
  localparam logic [31:0] ADDR_E     = 32'hF000_0150;  // set 42 in the error region

  logic                         clk;
  logic                         rst;
  logic                         ar_valid;
  logic                         ar_ready;
  icache_geom_pkg::fetch_addr_u ar_addr;
  logic                         r_valid;
  logic                         r_ready = 1'b0;
  icache_bus_pkg::fetch_rsp_t   r_rsp;
  logic                         mem_ar_valid;
  logic                         mem_ar_ready;
  logic [31:0]                  mem_ar_addr;
  logic                         mem_r_valid;
  logic                         mem_r_ready;
  icache_bus_pkg::mem_rsp_t     mem_r_rsp;
  logic                         cfg_we;
  icache_bus_pkg::cfg_addr_e    cfg_addr;
  logic [31:0]                  cfg_wdata;
  logic [31:0]                  cfg_rdata;

  logic [31:0]                lfsr_q = LFSR_SEED;
  logic [2:0]                 rnd_bits;
  logic [1:0]                 mem_gate = 2'b00;
  string                      test_name = "reset";
  logic [31:0]                cur_addr = '0;
  logic                       exp_hit = 1'b0;
  logic                       enabled = 1'b1;  // cache comes out of reset enabled
  logic                       busy_q = 1'b0;
  logic                       refill_seen_q = 1'b0;
  logic                       refill_wait_q = 1'b0;
  logic                       hold_q = 1'b0;
  icache_bus_pkg::fetch_rsp_t rsp_prev_q = '0;
  logic                       rd_check = 1'b0;
  logic [31:0]                rd_expect = '0;
  int unsigned                hit_tally = 0;
  int unsigned                miss_tally = 0;
  int unsigned                assert_errs = 0;
  int unsigned                timeout_errs = 0;
  logic                       aborted = 1'b0;

  icache_tb_clk clk_gen_inst (.clk_o(clk), .rst_o(rst));

  icache_top icache_top_inst (
    .clk            (clk),
    .rst            (rst),
    .ar_valid_i     (ar_valid),
    .ar_ready_o     (ar_ready),
    .ar_addr_i      (ar_addr),
    .r_valid_o      (r_valid),
    .r_ready_i      (r_ready),
    .r_rsp_o        (r_rsp),
    .mem_ar_valid_o (mem_ar_valid),
    .mem_ar_ready_i (mem_ar_ready),
    .mem_ar_addr_o  (mem_ar_addr),
    .mem_r_valid_i  (mem_r_valid),
    .mem_r_ready_o  (mem_r_ready),
    .mem_r_rsp_i    (mem_r_rsp),
    .cfg_we_i       (cfg_we),
    .cfg_addr_i     (cfg_addr),
    .cfg_wdata_i    (cfg_wdata),
    .cfg_rdata_o    (cfg_rdata)
  );

  icache_mem_model mem_model_inst (
    .clk        (clk),
    .rst        (rst),
    .gate_i     (mem_gate),
    .ar_valid_i (mem_ar_valid),
    .ar_ready_o (mem_ar_ready),
    .ar_addr_i  (mem_ar_addr),
    .r_valid_o  (mem_r_valid),
    .r_ready_i  (mem_r_ready),
    .r_rsp_o    (mem_r_rsp)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? LFSR_TAPS : 32'h0);
  endfunction

  function automatic logic [63:0] rule_data(input logic [31:0] a);
    logic [31:0] line;
    line      = {a[31:3], 3'b000};
    rule_data = {~line, line};
  endfunction

  function automatic icache_bus_pkg::resp_e rule_resp(input logic [31:0] a);
    if (a[31:28] == 4'hF) begin
      rule_resp = icache_bus_pkg::SLVERR;
    end else begin
      rule_resp = icache_bus_pkg::OKAY;
    end
  endfunction

  // one line per set 16..31 with the offset taken from the set
  function automatic logic [31:0] sweep_addr(input int i);
    sweep_addr = {23'(i * 7 + 3), 6'(i), 3'(i)};
  endfunction

  // three bits per cycle for the memory slots and the fetch-side ready
  always @(posedge clk) begin
    for (int b = 0; b < 3; b++) begin
      rnd_bits[b] = lfsr_q[0];
      lfsr_q      = lfsr_next(lfsr_q);
    end
    mem_gate <= rnd_bits[1:0];
    r_ready  <= rnd_bits[2];
  end

  always @(posedge clk) begin
    if (rst) begin
      busy_q        <= 1'b0;
      refill_seen_q <= 1'b0;
      refill_wait_q <= 1'b0;
      hold_q        <= 1'b0;
    end else begin
      if (ar_valid && ar_ready) begin
        busy_q        <= 1'b1;
        refill_seen_q <= 1'b0;
      end else if (r_valid && r_ready) begin
        busy_q <= 1'b0;
      end
      if (mem_ar_valid && mem_ar_ready) begin
        refill_seen_q <= 1'b1;
        refill_wait_q <= 1'b1;
      end else if (mem_r_valid && mem_r_ready) begin
        refill_wait_q <= 1'b0;  // data handshake ends the refill
      end
      hold_q <= r_valid && !r_ready;  // response stalled
    end
    rsp_prev_q <= r_rsp;
  end

  data_check: assert property (@(posedge clk) disable iff (rst)
    r_valid |-> r_rsp.data == rule_data(cur_addr))
  else begin
    assert_errs++;
    $display("** Error: %s data expected %h actual %h", test_name, rule_data(cur_addr),
             $sampled(r_rsp.data));
  end

  resp_check: assert property (@(posedge clk) disable iff (rst)
    r_valid |-> r_rsp.resp == rule_resp(cur_addr))
  else begin
    assert_errs++;
    $display("** Error: %s resp expected %0d actual %0d", test_name, rule_resp(cur_addr),
             $sampled(r_rsp.resp));
  end

  hit_no_refill: assert property (@(posedge clk) disable iff (rst)
    (busy_q && exp_hit) |-> !mem_ar_valid)
  else begin
    assert_errs++;
    $display("** Error: %s refill request expected 0 actual %0b", test_name,
             $sampled(mem_ar_valid));
  end

  miss_refilled: assert property (@(posedge clk) disable iff (rst)
    (r_valid && !exp_hit) |-> refill_seen_q)
  else begin
    assert_errs++;
    $display("** Error: %s refill before response expected 1 actual %0b", test_name,
             $sampled(refill_seen_q));
  end

  refill_addr: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid |-> mem_ar_addr == {cur_addr[31:3], 3'b000})
  else begin
    assert_errs++;
    $display("** Error: %s refill address expected %h actual %h", test_name,
             {cur_addr[31:3], 3'b000}, $sampled(mem_ar_addr));
  end

  refill_ready: assert property (@(posedge clk) disable iff (rst)
    mem_r_ready == refill_wait_q)
  else begin
    assert_errs++;
    $display("** Error: %s refill data ready expected %0b actual %0b", test_name,
             $sampled(refill_wait_q), $sampled(mem_r_ready));
  end

  rsp_held: assert property (@(posedge clk) disable iff (rst)
    hold_q |-> (r_valid && r_rsp == rsp_prev_q))
  else begin
    assert_errs++;
    $display("** Error: %s stalled response expected %h actual %h", test_name,
             $sampled(rsp_prev_q), $sampled(r_rsp));
  end

  one_outstanding: assert property (@(posedge clk) disable iff (rst)
    busy_q |-> !ar_ready)
  else begin
    assert_errs++;
    $display("** Error: %s ar_ready during fetch expected 0 actual %0b", test_name,
             $sampled(ar_ready));
  end

  no_stray_rsp: assert property (@(posedge clk) disable iff (rst)
    !busy_q |-> !r_valid)
  else begin
    assert_errs++;
    $display("%s: response appeared with no fetch in flight", test_name);
  end

  reg_value: assert property (@(posedge clk) disable iff (rst)
    rd_check |-> cfg_rdata == rd_expect)
  else begin
    assert_errs++;
    $display("** Error: %s register expected %0d actual %0d", test_name, rd_expect,
             $sampled(cfg_rdata));
  end

  task automatic timeout_hit(input string what);
    timeout_errs++;
    aborted = 1'b1;  // remaining steps are skipped
    $display("%s: gave up waiting for the %s", test_name, what);
  endtask

  task automatic fetch(input string name, input logic [31:0] addr, input logic hit);
    int   waited;
    logic done;
    if (!aborted) begin
      @(posedge clk);
      test_name = name;
      cur_addr     <= addr;
      exp_hit      <= hit;
      ar_valid     <= 1'b1;
      ar_addr.raw  <= addr;
      waited = 0;
      done   = 1'b0;
      while (!done && !aborted) begin
        @(posedge clk);
        waited++;
        if (ar_ready) begin
          done = 1'b1;
        end else if (waited > WAIT_LIMIT) begin
          timeout_hit("fetch address handshake");
        end
      end
      ar_valid <= 1'b0;
      waited = 0;
      done   = 1'b0;
      while (!done && !aborted) begin
        @(posedge clk);
        waited++;
        if (r_valid && r_ready) begin
          done = 1'b1;
        end else if (waited > WAIT_LIMIT) begin
          timeout_hit("fetch response");
        end
      end
      if (done && enabled) begin
        if (hit) begin
          hit_tally++;
        end else begin
          miss_tally++;
        end
      end
    end
  endtask

  task automatic write_ctrl(input logic en, input logic flush);
    if (!aborted) begin
      @(posedge clk);
      cfg_we    <= 1'b1;
      cfg_addr  <= icache_bus_pkg::CTRL;
      cfg_wdata <= {30'b0, flush, en};
      @(posedge clk);
      cfg_we <= 1'b0;
      enabled = en;
    end
  endtask

  task automatic read_reg(input string name, input icache_bus_pkg::cfg_addr_e sel,
                          input logic [31:0] want);
    if (!aborted) begin
      @(posedge clk);
      test_name = name;
      cfg_addr  <= sel;
      rd_expect <= want;
      rd_check  <= 1'b1;
      @(posedge clk);
      rd_check <= 1'b0;
    end
  endtask

  initial begin
    int waited;
    ar_valid  = 1'b0;
    ar_addr   = '0;
    cfg_we    = 1'b0;
    cfg_addr  = icache_bus_pkg::CTRL;
    cfg_wdata = '0;
    waited    = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (rst && waited < WAIT_LIMIT);
    if (rst) begin
      timeout_hit("reset release");
    end
    read_reg("ctrl_after_reset", icache_bus_pkg::CTRL, 32'h1);

    fetch("first_fill", ADDR_A, 1'b0);
    fetch("same_line", ADDR_A + 32'd4, 1'b1);
    fetch("second_way", ADDR_B, 1'b0);
    fetch("both_ways_a", ADDR_A, 1'b1);
    fetch("both_ways_b", ADDR_B, 1'b1);
    for (int i = 16; i < 32; i++) begin
      fetch("sweep_fill", sweep_addr(i), 1'b0);
    end
    for (int i = 16; i < 32; i++) begin
      fetch("sweep_hit", sweep_addr(i), 1'b1);
    end

    write_ctrl(1'b1, 1'b1);  // flush and stay enabled
    fetch("after_flush_a", ADDR_A, 1'b0);
    fetch("after_flush_b", ADDR_B, 1'b0);
    fetch("refilled_a", ADDR_A, 1'b1);

    write_ctrl(1'b0, 1'b0);
    read_reg("ctrl_disabled", icache_bus_pkg::CTRL, 32'h0);
    fetch("bypass_a", ADDR_A, 1'b0);
    fetch("bypass_a_again", ADDR_A, 1'b0);
    fetch("bypass_c", ADDR_C, 1'b0);
    write_ctrl(1'b1, 1'b0);
    fetch("reenable_a", ADDR_A, 1'b0);  // bypass dropped the cached copy
    fetch("reenable_a_hit", ADDR_A, 1'b1);
    fetch("reenable_b", ADDR_B, 1'b1);
    fetch("reenable_c", ADDR_C, 1'b0);

    fetch("slverr", ADDR_E, 1'b0);
    fetch("slverr_again", ADDR_E + 32'd4, 1'b0);  // error line never filled
    read_reg("hit_count", icache_bus_pkg::HIT_COUNT, hit_tally);
    read_reg("miss_count", icache_bus_pkg::MISS_COUNT, miss_tally);
    repeat (4) @(posedge clk);

    $display("closing: %0d failed checks, %0d timeouts, %0d hits and %0d misses tallied",
             assert_errs, timeout_errs, hit_tally, miss_tally);
    if (assert_errs == 0 && timeout_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: verif/icache_tb_clk.sv
module icache_tb_clk (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD  = 10;  // period 20
  localparam int RESET_CYCLES = 3;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;  // drops on the third rising edge
  end

endmodule
